// File: hdl/axi_proto_pkg.sv
// AXI4 protocol limits and burst length type shared by the read master

package axi_proto_pkg;

  //////////////////////////////////////////////////
  // Burst limits
  //////////////////////////////////////////////////

  // Longest INCR burst allowed by AXI4, in beats
  localparam int axi_max_burst_beats = 256;

  // No burst may cross a 4 KB address boundary
  localparam int axi_max_burst_bytes = 4096;

  //////////////////////////////////////////////////
  // Channel field types
  //////////////////////////////////////////////////

  // Beats in a burst minus one, as carried on arlen
  typedef logic [7:0] axi_len_t;

endpackage : axi_proto_pkg

// File: hdl/rd_master_pkg.sv
// Read master FSM states and sizing helpers derived from the data width

package rd_master_pkg;

  import axi_proto_pkg::*;

  //////////////////////////////////////////////////
  // Address issue FSM
  //////////////////////////////////////////////////

  typedef enum logic [1:0] {
    // Nothing left to issue
    AR_IDLE,
    // arvalid is up, waiting for arready
    AR_ISSUE,
    // Gap after a handshake, or outstanding limit reached
    AR_STALL
  } ar_state_t;

  //////////////////////////////////////////////////
  // Sizing helpers
  //////////////////////////////////////////////////

  // Bytes moved per data beat
  function automatic int data_bytes_f(int data_width);
    return data_width / 8;
  endfunction

  // Address bits covered by one beat
  function automatic int data_bytes_log2_f(int data_width);
    return $clog2(data_width / 8);
  endfunction

  // Beats in a full burst, capped by length and by the 4 KB boundary
  function automatic int burst_beats_f(int data_width);
    int by_boundary;
    by_boundary = axi_max_burst_bytes / (data_width / 8);
    return (by_boundary < axi_max_burst_beats) ? by_boundary : axi_max_burst_beats;
  endfunction

  // Beat index bits within one full burst
  function automatic int burst_beats_log2_f(int data_width);
    return $clog2(burst_beats_f(data_width));
  endfunction

  // Bytes covered by a full burst, which is also the address step
  function automatic int burst_bytes_f(int data_width);
    return burst_beats_f(data_width) * data_bytes_f(data_width);
  endfunction

  // Width of a beat count derived from a byte count
  function automatic int total_len_width_f(int xfer_size_width, int data_width);
    return xfer_size_width - data_bytes_log2_f(data_width);
  endfunction

  // Width of a burst count, i.e. beat count without the in-burst bits
  function automatic int burst_cnt_width_f(int xfer_size_width, int data_width);
    return total_len_width_f(xfer_size_width, data_width) - burst_beats_log2_f(data_width);
  endfunction

endpackage : rd_master_pkg

// File: hdl/burst_plan_if.sv
// Planned transfer handed from the transfer planner to the AR issuer

`timescale 1ns/1ps

interface burst_plan_if
  import axi_proto_pkg::*;
  import rd_master_pkg::*;
#(
  parameter int addr_width      = 64,
  parameter int data_width      = 32,
  parameter int xfer_size_width = 32
);

  localparam int burst_cnt_width = burst_cnt_width_f(xfer_size_width, data_width);

  // One cycle strobe, fields below are valid with it
  logic                       plan_valid;
  // Start address, already aligned to a full burst
  logic [addr_width-1:0]      base_addr;
  // Bursts in the transfer minus one
  logic [burst_cnt_width-1:0] num_full_bursts;
  // arlen of the last burst
  axi_len_t                   final_len;

  // Issuer has no ready, a plan is always taken
  modport planner (output plan_valid, base_addr, num_full_bursts, final_len);
  modport issuer  (input  plan_valid, base_addr, num_full_bursts, final_len);

endinterface : burst_plan_if

// File: hdl/xfer_planner.sv
// Transfer planner: rounds a byte request to beats, aligns it and splits it into bursts

`timescale 1ns/1ps

module xfer_planner
  import axi_proto_pkg::*;
  import rd_master_pkg::*;
#(
  parameter int addr_width      = 64,
  parameter int data_width      = 32,
  parameter int xfer_size_width = 32
) (
  input  logic                       aclk,
  input  logic                       areset,
  input  logic                       start,
  input  logic [addr_width-1:0]      addr_offset,
  input  logic [xfer_size_width-1:0] xfer_size_bytes,
  burst_plan_if.planner              plan
);

  localparam int log_db          = data_bytes_log2_f(data_width);
  localparam int log_burst       = burst_beats_log2_f(data_width);
  localparam int total_len_width = total_len_width_f(xfer_size_width, data_width);
  localparam int burst_cnt_width = burst_cnt_width_f(xfer_size_width, data_width);
  // Byte offset bits inside one full burst
  localparam logic [addr_width-1:0] addr_mask = addr_width'(burst_bytes_f(data_width) - 1);

  // Beats minus one, arlen style
  logic [total_len_width-1:0] total_len_r;
  logic [addr_width-1:0]      addr_r;
  logic                       start_d1;
  logic                       start_d2;

  //////////////////////////////////////////////////
  // Request capture, edge 0
  //////////////////////////////////////////////////

  always_ff @(posedge aclk) begin
    if (start) begin
      // A partial last beat still costs a whole beat
      if (xfer_size_bytes[0 +: log_db] != '0) begin
        total_len_r <= xfer_size_bytes[log_db +: total_len_width];
      end else begin
        total_len_r <= xfer_size_bytes[log_db +: total_len_width] - 1'b1;
      end
      // Drop the low bits so no burst crosses 4 KB
      addr_r <= addr_offset & ~addr_mask;
    end
  end

  //////////////////////////////////////////////////
  // Burst split, edge 1
  //////////////////////////////////////////////////

  // Upper beat bits count bursts minus one, lower bits give the last arlen
  // All ones in the lower bits means the last burst is a full one
  always_ff @(posedge aclk) begin
    if (start_d1) begin
      plan.base_addr       <= addr_r;
      plan.num_full_bursts <= total_len_r[log_burst +: burst_cnt_width];
      plan.final_len       <= axi_len_t'(total_len_r[0 +: log_burst]);
    end
  end

  // Strobe delay line, plan_valid follows edge 2
  always_ff @(posedge aclk) begin
    if (areset) begin
      start_d1        <= 1'b0;
      start_d2        <= 1'b0;
      plan.plan_valid <= 1'b0;
    end else begin
      start_d1        <= start;
      start_d2        <= start_d1;
      plan.plan_valid <= start_d2;
    end
  end

endmodule : xfer_planner

// File: hdl/ar_issuer.sv
// AR channel issuer: walks the planned bursts and caps the bursts in flight

`timescale 1ns/1ps

module ar_issuer
  import axi_proto_pkg::*;
  import rd_master_pkg::*;
#(
  parameter int addr_width      = 64,
  parameter int data_width      = 32,
  parameter int xfer_size_width = 32,
  parameter int max_outstanding = 16
) (
  input  logic            aclk,
  input  logic            areset,
  burst_plan_if.issuer    plan,
  input  logic            burst_done,
  output logic            arvalid,
  input  logic            arready,
  output logic [addr_width-1:0] araddr,
  output axi_len_t        arlen
);

  localparam int burst_cnt_width = burst_cnt_width_f(xfer_size_width, data_width);
  localparam int vac_width       = $clog2(max_outstanding + 1);
  // Full burst arlen and the address step between bursts
  localparam axi_len_t              full_len   = axi_len_t'(burst_beats_f(data_width) - 1);
  localparam logic [addr_width-1:0] addr_step  = addr_width'(burst_bytes_f(data_width));

  ar_state_t                  state;
  ar_state_t                  state_nxt;
  logic [burst_cnt_width-1:0] bursts_to_go;
  logic [vac_width-1:0]       vacancy;
  logic [addr_width-1:0]      addr_r;
  axi_len_t                   final_len_r;
  logic                       arxfer;
  logic                       last_burst;
  logic                       can_issue;

  assign arxfer     = arvalid & arready;
  assign last_burst = (bursts_to_go == '0);
  // At least one slot free for another burst
  assign can_issue  = (vacancy != '0);

  //////////////////////////////////////////////////
  // AR channel outputs
  //////////////////////////////////////////////////

  assign arvalid = (state == AR_ISSUE);
  assign araddr  = addr_r;
  assign arlen   = last_burst ? final_len_r : full_len;

  //////////////////////////////////////////////////
  // Issue FSM
  //////////////////////////////////////////////////

  always_comb begin
    state_nxt = state;
    case (state)
      AR_IDLE: begin
        if (plan.plan_valid) begin
          state_nxt = can_issue ? AR_ISSUE : AR_STALL;
        end
      end
      AR_ISSUE: begin
        // Every handshake is followed by at least one idle cycle
        if (arxfer) begin
          state_nxt = last_burst ? AR_IDLE : AR_STALL;
        end
      end
      AR_STALL: begin
        if (can_issue) begin
          state_nxt = AR_ISSUE;
        end
      end
      default: state_nxt = AR_IDLE;
    endcase
  end

  always_ff @(posedge aclk) begin
    if (areset) begin
      state <= AR_IDLE;
    end else begin
      state <= state_nxt;
    end
  end

  // Bursts still to issue after the current one
  always_ff @(posedge aclk) begin
    if (areset) begin
      bursts_to_go <= '0;
    end else if (plan.plan_valid) begin
      bursts_to_go <= plan.num_full_bursts;
    end else if (arxfer && !last_burst) begin
      bursts_to_go <= bursts_to_go - 1'b1;
    end
  end

  // Free slots, up on a finished burst and down on each AR handshake
  always_ff @(posedge aclk) begin
    if (areset) begin
      vacancy <= vac_width'(max_outstanding);
    end else if (burst_done && !arxfer) begin
      vacancy <= vacancy + 1'b1;
    end else if (arxfer && !burst_done) begin
      vacancy <= vacancy - 1'b1;
    end
  end

  // Address and last length are taken with the plan
  always_ff @(posedge aclk) begin
    if (plan.plan_valid) begin
      addr_r      <= plan.base_addr;
      final_len_r <= plan.final_len;
    end else if (arxfer) begin
      addr_r <= addr_r + addr_step;
    end
  end

endmodule : ar_issuer

// File: hdl/r_tracker.sv
// Read data tracker: forwards R beats to the stream and flags the end of the transfer

`timescale 1ns/1ps

module r_tracker
  import rd_master_pkg::*;
#(
  parameter int data_width      = 32,
  parameter int xfer_size_width = 32
) (
  input  logic                       aclk,
  input  logic                       areset,
  input  logic                       plan_valid,
  input  logic [burst_cnt_width_f(xfer_size_width, data_width)-1:0] num_full_bursts,
  // AXI4 R channel
  input  logic                       rvalid,
  output logic                       rready,
  input  logic [data_width-1:0]      rdata,
  input  logic                       rlast,
  // AXI4-Stream master
  output logic                       tvalid,
  input  logic                       tready,
  output logic [data_width-1:0]      tdata,
  output logic                       tlast,
  // Completion
  output logic                       burst_done,
  output logic                       done
);

  localparam int burst_cnt_width = burst_cnt_width_f(xfer_size_width, data_width);

  logic [burst_cnt_width-1:0] bursts_left;
  logic                       rxfer;
  logic                       last_burst;

  //////////////////////////////////////////////////
  // Stream pass-through
  //////////////////////////////////////////////////

  // No buffering, so the slave sees the stream back-pressure directly
  assign tvalid = rvalid;
  assign tdata  = rdata;
  assign tlast  = rlast;
  assign rready = tready;

  assign rxfer      = rvalid & rready;
  // Same cycle as the stream handshake with tlast
  assign burst_done = rxfer & rlast;
  assign last_burst = (bursts_left == '0);

  //////////////////////////////////////////////////
  // Burst count and done
  //////////////////////////////////////////////////

  // Bursts still expected after the current one
  always_ff @(posedge aclk) begin
    if (areset) begin
      bursts_left <= '0;
    end else if (plan_valid) begin
      bursts_left <= num_full_bursts;
    end else if (burst_done && !last_burst) begin
      bursts_left <= bursts_left - 1'b1;
    end
  end

  // One cycle pulse after the final rlast
  always_ff @(posedge aclk) begin
    if (areset) begin
      done <= 1'b0;
    end else begin
      done <= burst_done & last_burst;
    end
  end

endmodule : r_tracker

// File: hdl/axi_read_master.sv
// AXI4 read master: splits a byte transfer into bursts and streams the read data

`timescale 1ns/1ps

module axi_read_master
  import axi_proto_pkg::*;
#(
  parameter int addr_width      = 64,
  parameter int data_width      = 32,
  parameter int xfer_size_width = 32,
  parameter int max_outstanding = 16
) (
  input  logic                       aclk,
  input  logic                       areset,
  // Control, sampled with ctrl_start
  input  logic                       ctrl_start,
  output logic                       ctrl_done,
  input  logic [addr_width-1:0]      ctrl_addr_offset,
  input  logic [xfer_size_width-1:0] ctrl_xfer_size_in_bytes,
  // AXI4 AR channel
  output logic                       m_axi_arvalid,
  input  logic                       m_axi_arready,
  output logic [addr_width-1:0]      m_axi_araddr,
  output axi_len_t                   m_axi_arlen,
  // AXI4 R channel
  input  logic                       m_axi_rvalid,
  output logic                       m_axi_rready,
  input  logic [data_width-1:0]      m_axi_rdata,
  input  logic                       m_axi_rlast,
  // AXI4-Stream master
  output logic                       m_axis_tvalid,
  input  logic                       m_axis_tready,
  output logic [data_width-1:0]      m_axis_tdata,
  output logic                       m_axis_tlast
);

  // Finished burst, frees an outstanding slot in the issuer
  logic burst_done;

  burst_plan_if #(
    .addr_width      (addr_width),
    .data_width      (data_width),
    .xfer_size_width (xfer_size_width)
  ) plan_if ();

  //////////////////////////////////////////////////
  // Planner, issuer, tracker chain
  //////////////////////////////////////////////////

  xfer_planner #(
    .addr_width      (addr_width),
    .data_width      (data_width),
    .xfer_size_width (xfer_size_width)
  ) planner_i (
    .aclk            (aclk),
    .areset          (areset),
    .start           (ctrl_start),
    .addr_offset     (ctrl_addr_offset),
    .xfer_size_bytes (ctrl_xfer_size_in_bytes),
    .plan            (plan_if.planner)
  );

  ar_issuer #(
    .addr_width      (addr_width),
    .data_width      (data_width),
    .xfer_size_width (xfer_size_width),
    .max_outstanding (max_outstanding)
  ) issuer_i (
    .aclk       (aclk),
    .areset     (areset),
    .plan       (plan_if.issuer),
    .burst_done (burst_done),
    .arvalid    (m_axi_arvalid),
    .arready    (m_axi_arready),
    .araddr     (m_axi_araddr),
    .arlen      (m_axi_arlen)
  );

  // Tracker loads its burst count with the same plan strobe
  r_tracker #(
    .data_width      (data_width),
    .xfer_size_width (xfer_size_width)
  ) tracker_i (
    .aclk            (aclk),
    .areset          (areset),
    .plan_valid      (plan_if.plan_valid),
    .num_full_bursts (plan_if.num_full_bursts),
    .rvalid          (m_axi_rvalid),
    .rready          (m_axi_rready),
    .rdata           (m_axi_rdata),
    .rlast           (m_axi_rlast),
    .tvalid          (m_axis_tvalid),
    .tready          (m_axis_tready),
    .tdata           (m_axis_tdata),
    .tlast           (m_axis_tlast),
    .burst_done      (burst_done),
    .done            (ctrl_done)
  );

endmodule : axi_read_master

// File: tb/axi_mem_model.sv
// AXI4 read slave model with random response delay and an address based data pattern

`timescale 1ns/1ps

module axi_mem_model #(
  parameter int          addr_width = 32,
  parameter int          data_width = 32,
  parameter logic [31:0] seed_init  = 32'ha99d_c9f4
) (
  input  logic                  aclk,
  input  logic                  areset,
  // Holds every burst back for the longest delay
  input  logic                  slow,
  input  logic                  arvalid,
  output logic                  arready,
  input  logic [addr_width-1:0] araddr,
  input  logic [7:0]            arlen,
  output logic                  rvalid,
  input  logic                  rready,
  output logic [data_width-1:0] rdata,
  output logic                  rlast
);

  localparam int beat_bytes = data_width / 8;

  logic [addr_width-1:0] addr_q[$];
  logic [7:0]            len_q[$];
  integer                seed = seed_init;
  logic [addr_width-1:0] cur_addr;
  int                    cur_len;
  int                    beat;
  int                    delay;
  logic                  busy;
  logic                  hs;
  logic                  slow_s;

  //////////////////////////////////////////////////
  // AR channel
  //////////////////////////////////////////////////

  // Requests are queued at the edge, R side pops them 1 ns later
  initial begin
    arready = 1'b0;
    forever begin
      @(posedge aclk);
      if (areset) begin
        addr_q.delete();
        len_q.delete();
      end else if (arvalid && arready) begin
        addr_q.push_back(araddr);
        len_q.push_back(arlen);
      end
      #1;
      arready = areset ? 1'b0 : 1'($random(seed));
    end
  end

  //////////////////////////////////////////////////
  // R channel
  //////////////////////////////////////////////////

  initial begin
    rvalid   = 1'b0;
    rdata    = '0;
    rlast    = 1'b0;
    busy     = 1'b0;
    beat     = 0;
    delay    = 0;
    cur_len  = 0;
    cur_addr = '0;
    forever begin
      @(posedge aclk);
      hs     = rvalid && rready;
      slow_s = slow;
      #1;
      if (areset) begin
        busy = 1'b0;
      end else begin
        if (hs) begin
          if (beat == cur_len) begin
            busy = 1'b0;
          end else begin
            beat = beat + 1;
          end
        end
        // Bursts are answered strictly in order
        if (!busy && addr_q.size() != 0) begin
          cur_addr = addr_q.pop_front();
          cur_len  = int'(len_q.pop_front());
          beat     = 0;
          busy     = 1'b1;
          delay    = slow_s ? 7 : int'($random(seed) & 32'd7);
        end else if (busy && delay != 0) begin
          delay = delay - 1;
        end
      end
      rvalid = busy && (delay == 0);
      // Pattern is the beat's byte address with a fixed XOR
      rdata  = data_width'(cur_addr + addr_width'(beat * beat_bytes)) ^ 32'h5a5a_0000;
      rlast  = (beat == cur_len);
    end
  end

endmodule : axi_mem_model

// File: tb/tb_axi_read_master.sv
// Testbench for the AXI4 read master against a randomized read slave

`timescale 1ns/1ps

module tb_axi_read_master;

  localparam int addr_width      = 32;
  localparam int data_width      = 32;
  localparam int max_outstanding = 4;
  localparam int timeout_cycles  = 20000;
  // Full burst for 32 bit data is 256 beats of 4 bytes
  localparam int full_beats      = 256;
  localparam int burst_bytes     = 1024;

  logic        aclk;
  logic        areset;
  logic        ctrl_start;
  logic        ctrl_done;
  logic [31:0] ctrl_addr_offset;
  logic [31:0] ctrl_xfer_size_in_bytes;
  logic        arvalid;
  logic        arready;
  logic [31:0] araddr;
  logic [7:0]  arlen;
  logic        rvalid;
  logic        rready;
  logic [31:0] rdata;
  logic        rlast;
  logic        tvalid;
  logic        tready;
  logic [31:0] tdata;
  logic        tlast;
  logic        slow;
  logic        rand_ready;
  integer      seed = 32'ha99d_c9f4;
  int          errors;
  int          tests_run;
  int          tests_failed;
  logic        timed_out;
  // Expected transfer set up with ctrl_start
  logic [31:0] exp_base;
  int          exp_beats;
  int          exp_bursts;
  int          exp_final_len;
  // Progress of the running transfer
  int          ar_cnt;
  int          beat_cnt;
  int          tlast_cnt;
  logic        final_seen;

  axi_read_master #(
    .addr_width      (addr_width),
    .data_width      (data_width),
    .max_outstanding (max_outstanding)
  ) dut_i (
    .aclk (aclk), .areset (areset),
    .ctrl_start (ctrl_start), .ctrl_done (ctrl_done),
    .ctrl_addr_offset (ctrl_addr_offset), .ctrl_xfer_size_in_bytes (ctrl_xfer_size_in_bytes),
    .m_axi_arvalid (arvalid), .m_axi_arready (arready),
    .m_axi_araddr (araddr), .m_axi_arlen (arlen),
    .m_axi_rvalid (rvalid), .m_axi_rready (rready),
    .m_axi_rdata (rdata), .m_axi_rlast (rlast),
    .m_axis_tvalid (tvalid), .m_axis_tready (tready),
    .m_axis_tdata (tdata), .m_axis_tlast (tlast)
  );

  axi_mem_model #(
    .addr_width (addr_width),
    .data_width (data_width),
    .seed_init  (32'ha99d_c9f4)
  ) mem_i (
    .aclk (aclk), .areset (areset), .slow (slow),
    .arvalid (arvalid), .arready (arready), .araddr (araddr), .arlen (arlen),
    .rvalid (rvalid), .rready (rready), .rdata (rdata), .rlast (rlast)
  );

  initial begin
    aclk = 1'b0;
    forever #20 aclk = ~aclk;
  end

  // Stream sink with random back-pressure when enabled
  initial begin
    tready = 1'b1;
    forever begin
      @(posedge aclk);
      #1;
      tready = rand_ready ? 1'($random(seed)) : 1'b1;
    end
  end

  //////////////////////////////////////////////////
  // Reference model
  //////////////////////////////////////////////////

  function automatic logic [7:0] expected_arlen(input int idx);
    return (idx == exp_bursts - 1) ? 8'(exp_final_len) : 8'(full_beats - 1);
  endfunction

  function automatic logic [31:0] beat_data(input int idx);
    return (exp_base + 32'(idx) * 4) ^ 32'h5a5a_0000;
  endfunction

  // Last beat of every full burst and of the whole transfer
  function automatic logic last_beat_expected(input int idx);
    return (idx % full_beats == full_beats - 1) || (idx == exp_beats - 1);
  endfunction

  always @(posedge aclk) begin
    if (areset || ctrl_start) begin
      ar_cnt     <= 0;
      beat_cnt   <= 0;
      tlast_cnt  <= 0;
      final_seen <= 1'b0;
    end else begin
      if (arvalid && arready) begin
        ar_cnt <= ar_cnt + 1;
      end
      if (tvalid && tready) begin
        beat_cnt <= beat_cnt + 1;
      end
      if (tvalid && tready && tlast) begin
        tlast_cnt <= tlast_cnt + 1;
      end
      // Final beat is known from the planned beat count alone
      final_seen <= tvalid && tready && (beat_cnt == exp_beats - 1);
    end
  end

  //////////////////////////////////////////////////
  // Checks
  //////////////////////////////////////////////////

  araddr_check: assert property (@(posedge aclk) disable iff (areset)
    arvalid && arready |-> araddr == exp_base + 32'(ar_cnt) * burst_bytes)
    else begin
      $display("mismatch m_axi_araddr: got %h expected %h", $sampled(araddr),
               exp_base + 32'($sampled(ar_cnt)) * burst_bytes);
      errors++;
    end

  arlen_check: assert property (@(posedge aclk) disable iff (areset)
    arvalid && arready |-> arlen == expected_arlen(ar_cnt))
    else begin
      $display("mismatch m_axi_arlen: got %h expected %h", $sampled(arlen),
               expected_arlen($sampled(ar_cnt)));
      errors++;
    end

  // Without a data buffer the slave sees the stream back-pressure directly
  rready_check: assert property (@(posedge aclk) disable iff (areset)
    rready == tready)
    else begin
      $display("mismatch m_axi_rready: got %h expected %h", $sampled(rready),
               $sampled(tready));
      errors++;
    end

  tdata_check: assert property (@(posedge aclk) disable iff (areset)
    tvalid && tready |-> tdata == beat_data(beat_cnt))
    else begin
      $display("mismatch m_axis_tdata: got %h expected %h", $sampled(tdata),
               beat_data($sampled(beat_cnt)));
      errors++;
    end

  tlast_check: assert property (@(posedge aclk) disable iff (areset)
    tvalid && tready |-> tlast == last_beat_expected(beat_cnt))
    else begin
      $display("mismatch m_axis_tlast: got %h expected %h", $sampled(tlast),
               last_beat_expected($sampled(beat_cnt)));
      errors++;
    end

  // A stalled beat must not change until it is taken
  hold_check: assert property (@(posedge aclk) disable iff (areset)
    tvalid && !tready |=> tvalid && $stable(tdata) && $stable(tlast))
    else begin
      $display("stream beat changed or was dropped while tready was low");
      errors++;
    end

  outstanding_check: assert property (@(posedge aclk) disable iff (areset)
    ar_cnt - tlast_cnt <= max_outstanding)
    else begin
      $display("more than %0d bursts outstanding", max_outstanding);
      errors++;
    end

  // Covers the one cycle width and the low level after reset
  done_check: assert property (@(posedge aclk) disable iff (areset)
    ctrl_done == final_seen)
    else begin
      $display("mismatch ctrl_done: got %h expected %h", $sampled(ctrl_done),
               $sampled(final_seen));
      errors++;
    end

  //////////////////////////////////////////////////
  // Stimulus
  //////////////////////////////////////////////////

  task automatic run_xfer(input string name, input logic [31:0] addr, input int size,
                          input logic rand_mode, input logic slow_mode);
    int   errors_before;
    int   cycles;
    logic got_done;
    errors_before = errors;
    cycles        = 0;
    got_done      = 1'b0;
    @(posedge aclk);
    #1;
    exp_beats               = (size + 3) / 4;
    exp_bursts              = (exp_beats + full_beats - 1) / full_beats;
    exp_final_len           = (exp_beats - 1) % full_beats;
    exp_base                = addr & ~32'(burst_bytes - 1);
    rand_ready              = rand_mode;
    slow                    = slow_mode;
    ctrl_addr_offset        = addr;
    ctrl_xfer_size_in_bytes = size;
    ctrl_start              = 1'b1;
    @(posedge aclk);
    #1;
    ctrl_start = 1'b0;
    while (!got_done && cycles < timeout_cycles) begin
      @(posedge aclk);
      #1;
      got_done = ctrl_done;
      cycles++;
    end
    if (!got_done) begin
      $display("test %s: no ctrl_done within %0d cycles", name, timeout_cycles);
      timed_out = 1'b1;
    end else begin
      // Let the done check see the falling edge too
      repeat (2) @(posedge aclk);
      #1;
      ar_count_check: assert (ar_cnt == exp_bursts) else begin
        $display("mismatch AR handshake count: got %h expected %h", ar_cnt, exp_bursts);
        errors++;
      end
      beat_count_check: assert (beat_cnt == exp_beats) else begin
        $display("mismatch stream beat count: got %h expected %h", beat_cnt, exp_beats);
        errors++;
      end
    end
    tests_run++;
    if (errors != errors_before || !got_done) begin
      tests_failed++;
      $display("test %s: fail, %0d errors", name, errors - errors_before);
    end else begin
      $display("test %s: pass", name);
    end
  endtask

  initial begin
    areset                  = 1'b1;
    ctrl_start              = 1'b0;
    ctrl_addr_offset        = '0;
    ctrl_xfer_size_in_bytes = '0;
    slow                    = 1'b0;
    rand_ready              = 1'b0;
    errors                  = 0;
    tests_run               = 0;
    tests_failed            = 0;
    timed_out               = 1'b0;
    exp_base                = '0;
    exp_beats               = 0;
    exp_bursts              = 0;
    exp_final_len           = 0;
    repeat (2) @(posedge aclk);
    #1;
    areset = 1'b0;
    run_xfer("single partial burst", 32'h0000_0000, 100, 1'b0, 1'b0);
    if (!timed_out) run_xfer("multi burst split", 32'h0000_1000, 2600, 1'b0, 1'b0);
    if (!timed_out) run_xfer("address alignment", 32'h0000_1234, 64, 1'b0, 1'b0);
    if (!timed_out) run_xfer("stream back-pressure", 32'h0000_8000, 3000, 1'b1, 1'b0);
    if (!timed_out) run_xfer("outstanding limit", 32'h0001_0000, 10240, 1'b1, 1'b1);
    if (!timed_out) run_xfer("done pulse single beat", 32'h0000_3ffc, 4, 1'b1, 1'b0);
    $display("tests run %0d, passed %0d, failed %0d", tests_run,
             tests_run - tests_failed, tests_failed);
    if (errors == 0 && tests_failed == 0 && !timed_out) begin
      $display("Test passed");
    end else begin
      $display("Test failed");
    end
    $finish;
  end

endmodule : tb_axi_read_master

// File: src.f
hdl/axi_proto_pkg.sv
hdl/rd_master_pkg.sv
hdl/burst_plan_if.sv
hdl/xfer_planner.sv
hdl/ar_issuer.sv
hdl/r_tracker.sv
hdl/axi_read_master.sv
tb/axi_mem_model.sv
tb/tb_axi_read_master.sv

// File: run.sh
#!/bin/sh
# Build and run the read master testbench with Verilator
set -e
cd "$(dirname "$0")"
verilator --binary --timing --assert -Wno-fatal -f src.f \
  --top-module tb_axi_read_master -o sim_tb
output=$(./obj_dir/sim_tb)
echo "$output"
if echo "$output" | grep -qx "Test passed"; then
  exit 0
else
  exit 1
fi
